/* ctrlPkg.sv */
package ctrlPkg;

    // next pc source
    localparam logic [1:0] pcSeq    = 2'd0;
    localparam logic [1:0] pcBranch = 2'd1;
    localparam logic [1:0] pcJal    = 2'd2;
    localparam logic [1:0] pcJalr   = 2'd3;

    // alu operand b source
    localparam logic [1:0] bReg  = 2'd0;
    localparam logic [1:0] bImmI = 2'd1;
    localparam logic [1:0] bImmS = 2'd2;
    localparam logic [1:0] bImmU = 2'd3;

    localparam logic [3:0] aluAdd  = 4'd0;
    localparam logic [3:0] aluSub  = 4'd1;
    localparam logic [3:0] aluSll  = 4'd2;
    localparam logic [3:0] aluSlt  = 4'd3;
    localparam logic [3:0] aluSltu = 4'd4;
    localparam logic [3:0] aluXor  = 4'd5;
    localparam logic [3:0] aluSrl  = 4'd6;
    localparam logic [3:0] aluSra  = 4'd7;
    localparam logic [3:0] aluOr   = 4'd8;
    localparam logic [3:0] aluAnd  = 4'd9;

    // writeback source
    localparam logic [2:0] wbAlu = 3'd0;
    localparam logic [2:0] wbMem = 3'd1;
    localparam logic [2:0] wbPc4 = 3'd2;
    localparam logic [2:0] wbImm = 3'd3;

    // memory access, loads then stores
    localparam logic [3:0] memNone = 4'd0;
    localparam logic [3:0] memLb   = 4'd1;
    localparam logic [3:0] memLh   = 4'd2;
    localparam logic [3:0] memLw   = 4'd3;
    localparam logic [3:0] memLbu  = 4'd4;
    localparam logic [3:0] memLhu  = 4'd5;
    localparam logic [3:0] memSb   = 4'd6;
    localparam logic [3:0] memSh   = 4'd7;
    localparam logic [3:0] memSw   = 4'd8;

    typedef struct packed {
        logic       regWe;      // regfile write enable
        logic [1:0] pcSel;
        logic [1:0] bSel;
        logic [3:0] aluFn;
        logic [2:0] wbSel;
        logic       bneq;       // branch on not equal
        logic       btype;
        logic       jump;
        logic       jumpReg;
        logic       lui;
        logic       auipc;
        logic [3:0] memOp;
    } ctrlT;

    // every inactive encoding is zero
    localparam ctrlT ctrlIdle = '0;

endpackage

/* rv32Pkg.sv */
package rv32Pkg;
    import ctrlPkg::*;

    localparam int xlen     = 32;
    localparam int romDepth = 64;
    localparam int romAddrW = $clog2(romDepth);
    localparam     romFile  = "program.hex";

    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opReg    = 7'b0110011;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rTypeT;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iTypeT;

    typedef struct packed {
        logic [6:0] immHi;      // imm[11:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;      // imm[4:0]
        logic [6:0] opcode;
    } sTypeT;

    typedef struct packed {
        logic       imm12;
        logic [5:0] immHi;      // imm[10:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] immLo;      // imm[4:1]
        logic       imm11;
        logic [6:0] opcode;
    } bTypeT;

    typedef struct packed {
        logic [19:0] imm;       // imm[31:12]
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } uTypeT;

    typedef struct packed {
        logic       imm20;
        logic [9:0] immLo;      // imm[10:1]
        logic       imm11;
        logic [7:0] immHi;      // imm[19:12]
        logic [4:0] rd;
        logic [6:0] opcode;
    } jTypeT;

    // one fetched word, six views
    typedef union packed {
        rTypeT r;
        iTypeT i;
        sTypeT s;
        bTypeT b;
        uTypeT u;
        jTypeT j;
    } instrU;

    typedef struct packed {
        ctrlT            ctrl;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [4:0]      rd;
        logic [4:0]      shamt;
        logic [xlen-1:0] immI;
        logic [xlen-1:0] immS;
        logic [xlen-1:0] immB;
        logic [xlen-1:0] immU;
        logic [xlen-1:0] immJ;
        logic [xlen-1:0] pc;
    } decodeBusT;

endpackage

/* fetchStage.sv */
`timescale 1ns/1ps

module fetchStage
    import rv32Pkg::*;
(
    input  logic            clk,
    input  logic            nrst,
    input  logic            redirect,   // one cycle strobe
    input  logic [xlen-1:0] target,
    output logic [xlen-1:0] instr,
    output logic [xlen-1:0] pc
);

    logic [xlen-1:0]     rom [romDepth];
    logic [xlen-1:0]     pcNext;
    logic [romAddrW-1:0] romIdx;

    // words past the end of the file stay zero
    initial
    begin
        for (int k = 0; k < romDepth; k++)
        begin
            rom[k] = '0;
        end
        $readmemh(romFile, rom);
    end

    assign pcNext = redirect ? target : pc + xlen'(4);

    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            pc <= '0;
        end
        else
        begin
            pc <= pcNext;
        end
    end

    assign romIdx = pc[romAddrW+1:2];   // word index, wraps in rom
    assign instr  = rom[romIdx];

endmodule

/* instrDecoder.sv */
`timescale 1ns/1ps

module instrDecoder
    import rv32Pkg::*, ctrlPkg::*;
(
    input  logic [6:0] opcode,
    input  logic [2:0] funct3,
    input  logic       bit30,
    output ctrlT       ctrl
);

    // integer alu op, alt picks sub or sra
    function automatic logic [3:0] aluOp(input logic [2:0] f3, input logic alt);
        logic [3:0] fn;
        case (f3)
            3'b000:  fn = alt ? aluSub : aluAdd;
            3'b001:  fn = aluSll;
            3'b010:  fn = aluSlt;
            3'b011:  fn = aluSltu;
            3'b100:  fn = aluXor;
            3'b101:  fn = alt ? aluSra : aluSrl;
            3'b110:  fn = aluOr;
            default: fn = aluAnd;
        endcase
        return fn;
    endfunction

    function automatic logic [3:0] loadOp(input logic [2:0] f3);
        logic [3:0] op;
        case (f3)
            3'b000:  op = memLb;
            3'b001:  op = memLh;
            3'b010:  op = memLw;
            3'b100:  op = memLbu;
            3'b101:  op = memLhu;
            default: op = memNone;  // reserved width
        endcase
        return op;
    endfunction

    function automatic logic [3:0] storeOp(input logic [2:0] f3);
        logic [3:0] op;
        case (f3)
            3'b000:  op = memSb;
            3'b001:  op = memSh;
            3'b010:  op = memSw;
            default: op = memNone;
        endcase
        return op;
    endfunction

    always_comb
    begin
        ctrl = ctrlIdle;
        case (opcode)
            opReg:
            begin
                ctrl.regWe = 1'b1;
                ctrl.bSel  = bReg;
                ctrl.aluFn = aluOp(funct3, bit30);
            end
            opImm:
            begin
                ctrl.regWe = 1'b1;
                ctrl.bSel  = bImmI;
                ctrl.aluFn = aluOp(funct3, bit30 && funct3 == 3'b101);  // no subi
            end
            opLoad:
            begin
                ctrl.regWe = 1'b1;
                ctrl.bSel  = bImmI;
                ctrl.aluFn = aluAdd;        // address calc
                ctrl.wbSel = wbMem;
                ctrl.memOp = loadOp(funct3);
            end
            opStore:
            begin
                ctrl.bSel  = bImmS;
                ctrl.aluFn = aluAdd;
                ctrl.memOp = storeOp(funct3);
            end
            opBranch:
            begin
                ctrl.btype = 1'b1;
                ctrl.pcSel = pcBranch;
                ctrl.aluFn = aluSub;        // compare operands
                ctrl.bneq  = (funct3 == 3'b001);
            end
            opJal:
            begin
                ctrl.jump  = 1'b1;
                ctrl.pcSel = pcJal;
                ctrl.wbSel = wbPc4;         // link address
                ctrl.regWe = 1'b1;
            end
            opJalr:
            begin
                ctrl.jumpReg = 1'b1;
                ctrl.pcSel   = pcJalr;
                ctrl.wbSel   = wbPc4;
                ctrl.regWe   = 1'b1;
                ctrl.aluFn   = aluAdd;      // rs1 + immI target
                ctrl.bSel    = bImmI;
            end
            opLui:
            begin
                ctrl.lui   = 1'b1;
                ctrl.wbSel = wbImm;
                ctrl.regWe = 1'b1;
            end
            opAuipc:
            begin
                ctrl.auipc = 1'b1;
                ctrl.bSel  = bImmU;
                ctrl.aluFn = aluAdd;        // pc + immU
                ctrl.regWe = 1'b1;
            end
            default:
            begin
                ctrl = ctrlIdle;            // csr, fence, system, zero word
            end
        endcase
    end

endmodule

/* instDecodeStage.sv */
`timescale 1ns/1ps

module instDecodeStage
    import rv32Pkg::*, ctrlPkg::*;
(
    input  logic            clk,
    input  logic            nrst,
    input  logic [xlen-1:0] instr,      // from fetch rom
    input  logic [xlen-1:0] pc,
    output decodeBusT       dec
);

    instrU           instrQ;
    logic [xlen-1:0] pcQ;
    ctrlT            ctrl;

    // fetch to decode pipe register
    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            instrQ <= '0;
            pcQ    <= '0;
        end
        else
        begin
            instrQ <= instr;
            pcQ    <= pc;
        end
    end

    instrDecoder uDecoder (
        .opcode (instrQ.r.opcode),
        .funct3 (instrQ.r.funct3),
        .bit30  (instrQ.r.funct7[5]),   // sub / sra select
        .ctrl   (ctrl)
    );

    always_comb
    begin
        dec.ctrl  = ctrl;
        dec.rs1   = instrQ.r.rs1;
        dec.rs2   = instrQ.r.rs2;
        dec.rd    = instrQ.r.rd;
        dec.shamt = instrQ.i.imm[4:0];
        dec.immI  = {{20{instrQ.i.imm[11]}}, instrQ.i.imm};
        dec.immS  = {{20{instrQ.s.immHi[6]}}, instrQ.s.immHi, instrQ.s.immLo};
        dec.immB  = {{19{instrQ.b.imm12}}, instrQ.b.imm12, instrQ.b.imm11,
                     instrQ.b.immHi, instrQ.b.immLo, 1'b0};
        dec.immU  = {instrQ.u.imm, 12'b0};
        dec.immJ  = {{11{instrQ.j.imm20}}, instrQ.j.imm20, instrQ.j.immHi,
                     instrQ.j.imm11, instrQ.j.immLo, 1'b0};
        dec.pc    = pcQ;
    end

endmodule

/* frontEndTop.sv */
`timescale 1ns/1ps

module frontEndTop
    import rv32Pkg::*;
(
    input  logic            clk,
    input  logic            nrst,
    input  logic            redirect,
    input  logic [xlen-1:0] target,     // used only on redirect
    output decodeBusT       dec
);

    logic [xlen-1:0] instr;             // rom word at fetch pc
    logic [xlen-1:0] pc;

    fetchStage uFetch (
        .clk      (clk),
        .nrst     (nrst),
        .redirect (redirect),
        .target   (target),
        .instr    (instr),
        .pc       (pc)
    );

    instDecodeStage uDecode (
        .clk   (clk),
        .nrst  (nrst),
        .instr (instr),
        .pc    (pc),
        .dec   (dec)
    );

endmodule

/* tbRefModel.svh */
// expected decode of one rv32i word, from the base ISA field layout

function automatic logic [31:0] immIOf(input logic [31:0] w);
    return {{20{w[31]}}, w[31:20]};
endfunction

function automatic logic [31:0] immSOf(input logic [31:0] w);
    return {{20{w[31]}}, w[31:25], w[11:7]};
endfunction

function automatic logic [31:0] immBOf(input logic [31:0] w);
    return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};    // bit 0 always zero
endfunction

function automatic logic [31:0] immUOf(input logic [31:0] w);
    return {w[31:12], 12'h000};
endfunction

function automatic logic [31:0] immJOf(input logic [31:0] w);
    return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
endfunction

function automatic ctrlT idleCtrl();
    ctrlT c;
    c       = '0;
    c.pcSel = pcSeq;
    c.bSel  = bReg;
    c.aluFn = aluAdd;
    c.wbSel = wbAlu;
    c.memOp = memNone;
    return c;
endfunction

function automatic logic [3:0] aluFnOf(input logic [2:0] f3, input logic alt);
    case (f3)
        3'b000:  return alt ? aluSub : aluAdd;
        3'b001:  return aluSll;
        3'b010:  return aluSlt;
        3'b011:  return aluSltu;
        3'b100:  return aluXor;
        3'b101:  return alt ? aluSra : aluSrl;
        3'b110:  return aluOr;
        default: return aluAnd;
    endcase
endfunction

// store flag on top, then funct3
function automatic logic [3:0] memOpOf(input logic store, input logic [2:0] f3);
    case ({store, f3})
        4'b0_000: return memLb;
        4'b0_001: return memLh;
        4'b0_010: return memLw;
        4'b0_100: return memLbu;
        4'b0_101: return memLhu;
        4'b1_000: return memSb;
        4'b1_001: return memSh;
        4'b1_010: return memSw;
        default:  return memNone;
    endcase
endfunction

function automatic ctrlT ctrlOf(input logic [31:0] w);
    instrU u;
    ctrlT  c;
    u = w;
    c = idleCtrl();
    case (u.r.opcode)
        opReg:
        begin
            c.regWe = 1'b1;
            c.aluFn = aluFnOf(u.r.funct3, w[30]);
        end
        opImm:
        begin
            c.regWe = 1'b1;
            c.bSel  = bImmI;
            c.aluFn = aluFnOf(u.i.funct3, w[30] && u.i.funct3 == 3'b101);  // only srai
        end
        opLoad:
        begin
            c.regWe = 1'b1;
            c.bSel  = bImmI;
            c.wbSel = wbMem;
            c.memOp = memOpOf(1'b0, u.i.funct3);
        end
        opStore:
        begin
            c.bSel  = bImmS;
            c.memOp = memOpOf(1'b1, u.s.funct3);
        end
        opBranch:
        begin
            c.btype = 1'b1;
            c.pcSel = pcBranch;
            c.aluFn = aluSub;
            c.bneq  = (u.b.funct3 == 3'b001);
        end
        opJal:
        begin
            c.jump  = 1'b1;
            c.pcSel = pcJal;
            c.wbSel = wbPc4;
            c.regWe = 1'b1;
        end
        opJalr:
        begin
            c.jumpReg = 1'b1;
            c.pcSel   = pcJalr;
            c.wbSel   = wbPc4;
            c.regWe   = 1'b1;
            c.bSel    = bImmI;
        end
        opLui:
        begin
            c.lui   = 1'b1;
            c.wbSel = wbImm;
            c.regWe = 1'b1;
        end
        opAuipc:
        begin
            c.auipc = 1'b1;
            c.bSel  = bImmU;
            c.regWe = 1'b1;
        end
        default:
        begin
            c = idleCtrl();     // system, fence, zero word
        end
    endcase
    return c;
endfunction

/* tbFrontEnd.sv */
`timescale 1ns/1ps

module tbFrontEnd
    import rv32Pkg::*, ctrlPkg::*;
();

    localparam int resetCycles = 3;
    localparam int seqCycles   = 40;      // runs past the end of the program
    localparam int rndCycles   = 200;
    localparam int cycleLimit  = resetCycles + seqCycles + rndCycles + 160;

    logic            clk;
    logic            nrst;
    logic            redirect;
    logic [xlen-1:0] target;
    decodeBusT       dec;

    logic [xlen-1:0] romImage [romDepth];
    logic [xlen-1:0] expFetchPc;
    logic [xlen-1:0] expPc;
    logic [xlen-1:0] expWord;
    logic            resetPhase;
    logic [31:0]     lfsr;
    int              errCount   = 0;
    int              checkCount = 0;
    int              cycleCount = 0;

    `include "tbRefModel.svh"

    frontEndTop dut (
        .clk      (clk),
        .nrst     (nrst),
        .redirect (redirect),
        .target   (target),
        .dec      (dec)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #50 clk = ~clk;
        end
    end

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic drawBits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++)
        begin
            lfsr = lfsrNext(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic logMismatch(input string name, input logic [31:0] expVal,
                               input logic [31:0] gotVal);
        errCount++;
        $display("[ERROR] %0t %s expected %h got %h", $time, name, expVal, gotVal);
    endtask

    task automatic reportTest(input string name, input int errStart);
        @(negedge clk);
        #1;
        $display("test %s finished, %0d errors", name, errCount - errStart);
    endtask

    // fetch pc model with the decode view one cycle behind
    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            expFetchPc <= '0;
            expPc      <= '0;
            expWord    <= '0;
        end
        else
        begin
            expPc      <= expFetchPc;
            expWord    <= romImage[expFetchPc[7:2]];
            expFetchPc <= redirect ? target : expFetchPc + 32'd4;
        end
    end

    always @(negedge clk)
    begin
        checkCount++;
    end

    always @(posedge clk)
    begin
        cycleCount++;
        if (cycleCount >= cycleLimit)
        begin
            $display("timeout after %0d cycles, the tests did not finish", cycleCount);
            $display("TB FAILED");
            $finish;
        end
    end

    // sampled mid cycle where dec is stable
    assert property (@(negedge clk) resetPhase |-> dec.pc == '0)
        else logMismatch("dec.pc in reset", 32'h0, dec.pc);
    assert property (@(negedge clk) resetPhase |-> dec.ctrl == idleCtrl())
        else logMismatch("dec.ctrl in reset", 32'(idleCtrl()), 32'(dec.ctrl));
    assert property (@(negedge clk) dec.pc == expPc)
        else logMismatch("dec.pc", expPc, dec.pc);
    assert property (@(negedge clk)
        {dec.rs1, dec.rs2, dec.rd, dec.shamt} ==
        {expWord[19:15], expWord[24:20], expWord[11:7], expWord[24:20]})
        else logMismatch("dec.rs1/rs2/rd/shamt",
            32'({expWord[19:15], expWord[24:20], expWord[11:7], expWord[24:20]}),
            32'({dec.rs1, dec.rs2, dec.rd, dec.shamt}));
    assert property (@(negedge clk) dec.immI == immIOf(expWord))
        else logMismatch("dec.immI", immIOf(expWord), dec.immI);
    assert property (@(negedge clk) dec.immS == immSOf(expWord))
        else logMismatch("dec.immS", immSOf(expWord), dec.immS);
    assert property (@(negedge clk) dec.immB == immBOf(expWord))
        else logMismatch("dec.immB", immBOf(expWord), dec.immB);
    assert property (@(negedge clk) dec.immU == immUOf(expWord))
        else logMismatch("dec.immU", immUOf(expWord), dec.immU);
    assert property (@(negedge clk) dec.immJ == immJOf(expWord))
        else logMismatch("dec.immJ", immJOf(expWord), dec.immJ);
    assert property (@(negedge clk) dec.ctrl == ctrlOf(expWord))
        else logMismatch("dec.ctrl", 32'(ctrlOf(expWord)), 32'(dec.ctrl));

    initial
    begin
        logic [31:0] gate;
        logic [31:0] pick;
        int          errStart;
        nrst       = 1'b0;
        redirect   = 1'b0;
        target     = '0;
        resetPhase = 1'b1;
        lfsr       = 32'h97011883;
        for (int k = 0; k < romDepth; k++)
        begin
            romImage[k] = '0;
        end
        $readmemh(romFile, romImage);

        repeat (resetCycles) @(posedge clk);
        nrst <= 1'b1;
        @(posedge clk);             // decode register still clear before this edge
        resetPhase <= 1'b0;
        reportTest("reset", 0);

        errStart = errCount;
        repeat (seqCycles) @(posedge clk);
        reportTest("sequential", errStart);

        errStart = errCount;
        repeat (rndCycles)
        begin
            @(posedge clk);
            drawBits(3, gate);
            drawBits(6, pick);
            redirect <= (gate[2:0] == 3'd0);                 // about one in eight
            target   <= {24'h0, pick[5:0], 2'b00};
        end
        repeat (2)
        begin
            @(posedge clk);
            drawBits(6, pick);
            redirect <= 1'b1;                               // back to back strobes
            target   <= {24'h0, pick[5:0], 2'b00};
        end
        @(posedge clk);
        redirect <= 1'b0;
        repeat (2) @(posedge clk);  // last strobe reaches decode
        reportTest("redirect", errStart);

        $display("checked %0d cycles, %0d errors", checkCount, errCount);
        if (errCount == 0)
        begin
            $display("TB PASSED");
        end
        else
        begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* program.hex */
// one rv32i instruction word per line in hex, from word address 0
FFB10093
00721193
06432293
FFF43393
55554493
01F65593
40375693
80086793
7FF97893
003100B3
40628233
009413B3
00C5A533
00F736B3
0128C833
015A59B3
418BDB33
01BD6CB3
01EEFE33
00410083
FF821183
10032283
00144383
FFE55483
00B60623
7ED71FA3
FEF82623
00208863
FE4190E3
001000EF
FFDFF06F
FF4280E7
ABCDE537
12345597
00000073

/* build.f */
+incdir+.
ctrlPkg.sv
rv32Pkg.sv
fetchStage.sv
instrDecoder.sv
instDecodeStage.sv
frontEndTop.sv
tbFrontEnd.sv

/* run.sh */
#!/bin/bash
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timescale 1ns/1ps -f build.f --top-module tbFrontEnd &&
    ./obj_dir/VtbFrontEnd | tee /dev/stderr | grep -qx "TB PASSED" &&
    echo "simulation passed" || { echo "simulation failed"; exit 1; }
